//--- hw/agu_pkg.sv
//==========================================================================
// load/store address generation shared definitions
// widths, size classes, control register numbers and the bus structs
// used between the operation stage, the TLB and the data cache
//==========================================================================
`default_nettype none

package agu_pkg;

  localparam int paddr_width = 44;
  localparam int page_bits   = 13;  // 8 KB pages
  localparam int half_bits   = 7;   // 128 byte half-lines
  localparam int bank_count  = 32;
  localparam int asid_width  = 24;
  localparam int vpage_width = paddr_width - page_bits;

  // control register numbers, thread select sits above these in bit 15
  localparam logic [14:0] csr_page   = 15'd12;
  localparam logic [14:0] csr_vmpage = 15'd13;

  typedef logic [2:0] sz_class_t;  // 0 to 6

  typedef struct packed {
    logic                   valid;
    logic                   thread;
    logic                   vm;
    logic                   km;     // kernel mode
    logic [paddr_width-1:0] addr;
    logic [4:0]             sz;
    logic                   st;
    logic                   split;
    logic [4:0]             bank0;
    logic [8:0]             reg_no;
    logic [8:0]             lsq;
    logic [9:0]             ii;
    logic [5:0]             wq;
  } mem_op_t;

  typedef struct packed {
    logic        en;
    logic [15:0] no;    // bit 15 picks the thread
    logic [63:0] data;  // identifier in 63:40
  } csr_wr_t;

  typedef struct packed {
    logic [asid_width-1:0]  asid;
    logic [vpage_width-1:0] vpage;
  } tlb_req_t;

  typedef struct packed {
    logic                   hit;
    logic                   present;
    logic                   sys;    // supervisor only
    logic [vpage_width-1:0] ppage;
  } tlb_entry_t;

  typedef struct packed {
    logic                   en;
    logic [paddr_width-1:8] addr_even;
    logic [paddr_width-1:8] addr_odd;
    logic                   odd;
    logic [1:0]             addr_low;
    logic [bank_count-1:0]  banks;
    logic [4:0]             bank0;
    logic [4:0]             sz;
    logic                   st;
    logic                   split;
    logic [8:0]             reg_no;
    logic [8:0]             lsq;
    logic [9:0]             ii;
    logic [5:0]             wq;
  } mem_req_t;

endpackage

`default_nettype wire

//--- hw/agu_ctx_regs.sv
//==========================================================================
// per-thread address space identifiers
// physical and virtual identifier for each of two threads, written by
// control register writes, selected for the operation in the stage
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module agu_ctx_regs (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire agu_pkg::csr_wr_t               csr,
  input  wire                                 thread,
  input  wire                                 vm,
  output logic [agu_pkg::asid_width-1:0]      asid
);

  logic [1:0][agu_pkg::asid_width-1:0] pproc;
  logic [1:0][agu_pkg::asid_width-1:0] vproc;
  logic                                csr_thread;

  assign csr_thread = csr.no[15];

  always_ff @(posedge clk) begin
    if (rst) begin
      pproc <= '0;
      vproc <= '0;
    end else if (csr.en) begin
      case (csr.no[14:0])
        agu_pkg::csr_page: begin
          pproc[csr_thread] <= csr.data[63:40];
        end
        agu_pkg::csr_vmpage: begin
          vproc[csr_thread] <= csr.data[63:40];
        end
        default: begin
        end
      endcase
    end
  end

  // guest ops translate through the virtual identifier
  always_comb begin
    if (vm) begin
      asid = vproc[thread];
    end else begin
      asid = pproc[thread];
    end
  end

endmodule

`default_nettype wire

//--- hw/agu_op_stage.sv
//==========================================================================
// address generation operation register
// holds one memory op under downstream stall, flushes on exception,
// builds the TLB key and decides enable, miss and page fault
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module agu_op_stage (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              except,
  input  wire                              out_stall,
  input  wire agu_pkg::mem_op_t            op,
  input  wire [agu_pkg::asid_width-1:0]    asid,
  input  wire agu_pkg::tlb_entry_t         tlb_main,
  input  wire agu_pkg::tlb_entry_t         tlb_next,
  input  wire                              page_carry,
  input  wire [1:0]                        fault_main,
  input  wire [1:0]                        fault_next,
  input  wire agu_pkg::mem_req_t           req_base,
  output agu_pkg::mem_op_t                 cur,
  output agu_pkg::tlb_req_t                tlb_req,
  output agu_pkg::mem_req_t                req,
  output logic                             tlb_miss,
  output logic                             page_fault,
  output logic [7:0]                       fault_code
);

  agu_pkg::mem_op_t op_q;
  logic             presented;
  logic             need_next;
  logic             miss;
  logic [1:0]       fault_vec;

  always_ff @(posedge clk) begin
    if (rst) begin
      op_q.valid <= 1'b0;
    end else if (except) begin
      op_q.valid <= 1'b0;
    end else if (!out_stall) begin
      if (op.valid) begin
        op_q <= op;
      end else begin
        op_q.valid <= 1'b0;  // previous op retires
      end
    end
  end

  assign cur = op_q;

  assign tlb_req.asid  = asid;
  assign tlb_req.vpage = op_q.addr[agu_pkg::paddr_width-1:agu_pkg::page_bits];

  // op shows downstream only when nothing holds or kills it
  assign presented = op_q.valid & ~out_stall & ~except;

  // second page only matters when the access crosses into it
  assign need_next = op_q.split & page_carry;

  assign miss      = ~tlb_main.hit | (need_next & ~tlb_next.hit);
  assign fault_vec = fault_main | (need_next ? fault_next : 2'b00);

  always_comb begin
    req        = req_base;
    req.en     = presented & ~miss & ~(|fault_vec);
    tlb_miss   = presented & miss;
    page_fault = presented & ~miss & (|fault_vec);
  end

  // bit 3 supervisor page from user, bit 0 not present
  always_comb begin
    fault_code = 8'h00;
    if (page_fault) begin
      fault_code[3] = fault_vec[1];
      fault_code[0] = fault_vec[0];
    end
  end

endmodule

`default_nettype wire

//--- hw/agu_bank_mask.sv
//==========================================================================
// data bank mask
// decodes the size code into a size class and sets a wrapping run of
// banks from the start bank, length from class and low address bits
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module agu_bank_mask (
  input  wire [4:0]                          sz,
  input  wire [4:0]                          bank0,
  input  wire [1:0]                          addr_low,
  output logic [agu_pkg::bank_count-1:0]     banks
);

  agu_pkg::sz_class_t sz_class;
  logic [2:0]         run_len;

  always_comb begin
    case (sz)
      5'd16: sz_class = 3'd0;
      5'd17: sz_class = 3'd1;
      5'd18, 5'h4, 5'h5, 5'h6: sz_class = 3'd2;
      5'h3: sz_class = 3'd4;  // long double
      5'h0, 5'h1, 5'h2, 5'hc, 5'hd, 5'he: sz_class = 3'd5;  // 128 bit
      5'hf: sz_class = 3'd6;  // fill and spill
      default: sz_class = 3'd3;
    endcase
  end

  // misaligned accesses spill into one more bank
  always_comb begin
    case (sz_class)
      3'd0: run_len = 3'd1;
      3'd1: run_len = (addr_low == 2'd3) ? 3'd2 : 3'd1;
      3'd2: run_len = (addr_low == 2'd0) ? 3'd1 : 3'd2;
      3'd3: run_len = (addr_low == 2'd0) ? 3'd2 : 3'd3;
      3'd4: run_len = (addr_low == 2'd3) ? 3'd4 : 3'd3;
      3'd5: run_len = (addr_low == 2'd0) ? 3'd4 : 3'd5;
      default: run_len = 3'd5;
    endcase
  end

  always_comb begin
    for (int i = 0; i < agu_pkg::bank_count; i++) begin
      logic [4:0] off;
      off      = 5'(i) - bank0;  // distance from start, mod 32
      banks[i] = off < {2'b00, run_len};
    end
  end

endmodule

`default_nettype wire

//--- hw/agu_addr_compose.sv
//==========================================================================
// half-line address composition
// increments the half-line index, forms even and odd physical
// half-line addresses from the TLB pages, checks page permissions
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module agu_addr_compose (
  input  wire agu_pkg::mem_op_t                 cur,
  input  wire [agu_pkg::bank_count-1:0]         banks,
  input  wire agu_pkg::tlb_entry_t              tlb_main,
  input  wire agu_pkg::tlb_entry_t              tlb_next,
  output agu_pkg::mem_req_t                     req_base,
  output logic                                  page_carry,
  output logic [1:0]                            fault_main,
  output logic [1:0]                            fault_next
);

  localparam int idx_width = agu_pkg::page_bits - agu_pkg::half_bits;

  logic [idx_width-1:0]             half_idx;
  logic [idx_width-1:0]             half_next;
  logic                             odd;
  logic [agu_pkg::vpage_width-1:0]  page_inc;

  assign half_idx = cur.addr[agu_pkg::page_bits-1:agu_pkg::half_bits];
  assign {page_carry, half_next} = {1'b0, half_idx} + {{idx_width{1'b0}}, 1'b1};

  assign odd = cur.addr[agu_pkg::half_bits];

  // the incremented half crosses into the next page on carry
  assign page_inc = page_carry ? tlb_next.ppage : tlb_main.ppage;

  always_comb begin
    req_base          = '0;
    req_base.en       = 1'b0;
    if (odd) begin
      req_base.addr_even = {page_inc, half_next[idx_width-1:1]};
      req_base.addr_odd  = {tlb_main.ppage, half_idx[idx_width-1:1]};
    end else begin
      req_base.addr_even = {tlb_main.ppage, half_idx[idx_width-1:1]};
      req_base.addr_odd  = {page_inc, half_next[idx_width-1:1]};
    end
    req_base.odd      = odd;
    req_base.addr_low = cur.addr[1:0];
    req_base.banks    = banks;
    req_base.bank0    = cur.bank0;
    req_base.sz       = cur.sz;
    req_base.st       = cur.st;
    req_base.split    = cur.split;
    req_base.reg_no   = cur.reg_no;
    req_base.lsq      = cur.lsq;
    req_base.ii       = cur.ii;
    req_base.wq       = cur.wq;
  end

  // bit 1 supervisor page from user mode, bit 0 not present
  assign fault_main = {tlb_main.sys & ~cur.km, ~tlb_main.present};
  assign fault_next = {tlb_next.sys & ~cur.km, ~tlb_next.present};

endmodule

`default_nettype wire

//--- hw/agu_top.sv
//==========================================================================
// load/store address generation stage
// one memory op per cycle, TLB lookup of the page and the next page,
// physical half-line addresses, bank mask and fault reporting
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module agu_top (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        except,
  input  wire                        out_stall,
  input  wire agu_pkg::mem_op_t      op,
  input  wire agu_pkg::csr_wr_t      csr,
  output wire agu_pkg::tlb_req_t     tlb_req,
  input  wire agu_pkg::tlb_entry_t   tlb_main,
  input  wire agu_pkg::tlb_entry_t   tlb_next,
  output wire agu_pkg::mem_req_t     req,
  output wire                        tlb_miss,
  output wire                        page_fault,
  output wire [7:0]                  fault_code
);

  wire agu_pkg::mem_op_t             cur;
  wire agu_pkg::mem_req_t            req_base;
  wire [agu_pkg::asid_width-1:0]     asid;
  wire [agu_pkg::bank_count-1:0]     banks;
  wire                               page_carry;
  wire [1:0]                         fault_main;
  wire [1:0]                         fault_next;

  agu_op_stage u_stage (
    .clk        (clk),
    .rst        (rst),
    .except     (except),
    .out_stall  (out_stall),
    .op         (op),
    .asid       (asid),
    .tlb_main   (tlb_main),
    .tlb_next   (tlb_next),
    .page_carry (page_carry),
    .fault_main (fault_main),
    .fault_next (fault_next),
    .req_base   (req_base),
    .cur        (cur),
    .tlb_req    (tlb_req),
    .req        (req),
    .tlb_miss   (tlb_miss),
    .page_fault (page_fault),
    .fault_code (fault_code)
  );

  agu_ctx_regs u_ctx (
    .clk    (clk),
    .rst    (rst),
    .csr    (csr),
    .thread (cur.thread),
    .vm     (cur.vm),
    .asid   (asid)
  );

  agu_bank_mask u_banks (
    .sz       (cur.sz),
    .bank0    (cur.bank0),
    .addr_low (cur.addr[1:0]),
    .banks    (banks)
  );

  agu_addr_compose u_compose (
    .cur        (cur),
    .banks      (banks),
    .tlb_main   (tlb_main),
    .tlb_next   (tlb_next),
    .req_base   (req_base),
    .page_carry (page_carry),
    .fault_main (fault_main),
    .fault_next (fault_next)
  );

endmodule

`default_nettype wire

//--- tb/agu_tb.sv
//==========================================================================
// address generation stage testbench
// directed tests against a small TLB model: bank masks, half-line
// addresses, faults, misses, stall, flush and address space identifiers
//==========================================================================
`timescale 1ns/1ps
`default_nettype none

module agu_tb;

  logic                clk;
  logic                rst;
  logic                except;
  logic                out_stall;
  agu_pkg::mem_op_t    op;
  agu_pkg::csr_wr_t    csr;
  agu_pkg::tlb_req_t   tlb_req;
  agu_pkg::tlb_entry_t tlb_main;
  agu_pkg::tlb_entry_t tlb_next;
  agu_pkg::mem_req_t   req;
  logic                tlb_miss;
  logic                page_fault;
  logic [7:0]          fault_code;

  logic [23:0]         tab_asid [0:7];
  logic [30:0]         tab_vpage [0:7];
  agu_pkg::tlb_entry_t tab_ent [0:7];
  int                  tab_used = 0;
  int seed;
  int checks = 0;
  int errors = 0;
  int cycles = 0;
  int cycle_limit = 2000;  // tests take about 270 cycles

  // size class per size code, then run length per class and low bits 0, 3, other
  int class_of [0:31] = '{5, 5, 5, 4, 2, 2, 2, 3,
                          3, 3, 3, 3, 5, 5, 5, 6,
                          0, 1, 2, 3, 3, 3, 3, 3,
                          3, 3, 3, 3, 3, 3, 3, 3};
  int run_tab [0:6][0:2] = '{'{1, 1, 1}, '{1, 2, 1}, '{1, 2, 2}, '{2, 3, 3},
                             '{3, 4, 3}, '{4, 5, 5}, '{5, 5, 5}};

  agu_top dut (
    .clk        (clk),
    .rst        (rst),
    .except     (except),
    .out_stall  (out_stall),
    .op         (op),
    .csr        (csr),
    .tlb_req    (tlb_req),
    .tlb_main   (tlb_main),
    .tlb_next   (tlb_next),
    .req        (req),
    .tlb_miss   (tlb_miss),
    .page_fault (page_fault),
    .fault_code (fault_code)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: tests still running after %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  // TLB model, answers the page and the page after it
  always_comb begin
    tlb_main = '0;
    tlb_next = '0;
    for (int i = 0; i < 8; i++) begin
      if (i < tab_used && tab_asid[i] == tlb_req.asid) begin
        if (tab_vpage[i] == tlb_req.vpage) begin
          tlb_main = tab_ent[i];
        end
        if (tab_vpage[i] == tlb_req.vpage + 31'd1) begin
          tlb_next = tab_ent[i];
        end
      end
    end
  end

  task automatic add_entry(input logic [30:0] vpage, input logic present, input logic sys,
                           input logic [30:0] ppage);
    tab_asid[tab_used]  = 24'h0;
    tab_vpage[tab_used] = vpage;
    tab_ent[tab_used]   = {1'b1, present, sys, ppage};
    tab_used++;
  endtask

  function automatic agu_pkg::mem_op_t make_op(input logic [30:0] vpage,
      input logic [12:0] off, input logic [4:0] sz, input logic split,
      input logic km, input logic [4:0] bank0);
    agu_pkg::mem_op_t o;
    o        = '0;
    o.valid  = 1'b1;
    o.km     = km;
    o.addr   = {vpage, off};
    o.sz     = sz;
    o.split  = split;
    o.bank0  = bank0;
    o.st     = 1'($random(seed));
    o.reg_no = 9'($random(seed));
    o.lsq    = 9'($random(seed));
    o.ii     = 10'($random(seed));
    o.wq     = 6'($random(seed));
    return o;
  endfunction

  function automatic logic [31:0] expected_banks(input logic [4:0] sz, input logic [4:0] bank0,
                                                 input logic [1:0] low);
    logic [31:0] mask;
    int col;
    int len;
    mask = '0;
    col  = (low == 2'd0) ? 0 : ((low == 2'd3) ? 1 : 2);
    len  = run_tab[class_of[sz]][col];
    for (int k = 0; k < len; k++) begin
      mask[(int'(bank0) + k) % 32] = 1'b1;  // wraps past bank 31
    end
    return mask;
  endfunction

  task automatic check_val(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_status(input logic en, input logic miss, input logic fault,
                              input logic [7:0] code);
    check_val("req.en", 64'(req.en), 64'(en));
    check_val("tlb_miss", 64'(tlb_miss), 64'(miss));
    check_val("page_fault", 64'(page_fault), 64'(fault));
    check_val("fault_code", 64'(fault_code), 64'(code));
  endtask

  // half-line addresses built from the physical line index
  task automatic check_request(input agu_pkg::mem_op_t o, input logic [30:0] pmain,
                               input logic [30:0] pnext);
    logic [6:0]  inc;
    logic [36:0] cur_hl;
    logic [36:0] nxt_hl;
    inc    = {1'b0, o.addr[12:7]} + 7'd1;
    cur_hl = {pmain, o.addr[12:7]};
    nxt_hl = {(inc[6] ? pnext : pmain), inc[5:0]};
    check_val("addr_even", 64'(req.addr_even), 64'(o.addr[7] ? nxt_hl[36:1] : cur_hl[36:1]));
    check_val("addr_odd", 64'(req.addr_odd), 64'(o.addr[7] ? cur_hl[36:1] : nxt_hl[36:1]));
    check_val("odd", 64'(req.odd), 64'(o.addr[7]));
    check_val("addr_low", 64'(req.addr_low), 64'(o.addr[1:0]));
    check_val("bookkeeping",
              64'({req.bank0, req.sz, req.st, req.split, req.reg_no, req.lsq, req.ii, req.wq}),
              64'({o.bank0, o.sz, o.st, o.split, o.reg_no, o.lsq, o.ii, o.wq}));
  endtask

  // one op accepted, returns in the cycle it is presented
  task automatic present_op(input agu_pkg::mem_op_t o);
    @(negedge clk);
    op = o;
    @(negedge clk);
    op.valid = 1'b0;
  endtask

  task automatic write_csr(input logic thread, input logic [14:0] no, input logic [23:0] id);
    @(negedge clk);
    csr.en   = 1'b1;
    csr.no   = {thread, no};
    csr.data = {id, 40'($random(seed))};
    @(negedge clk);
    csr.en = 1'b0;
  endtask

  task automatic test_bank_masks();
    logic [4:0] codes [0:7];
    logic [1:0] lows [0:2];
    logic [4:0] starts [0:3];
    logic [12:0] off;
    agu_pkg::mem_op_t o;
    codes  = '{5'd16, 5'd17, 5'd18, 5'd19, 5'd3, 5'd0, 5'd15, 5'd9};
    lows   = '{2'd0, 2'd1, 2'd3};
    starts = '{5'd0, 5'd7, 5'd30, 5'd31};
    for (int c = 0; c < 8; c++) begin
      for (int l = 0; l < 3; l++) begin
        for (int s = 0; s < 4; s++) begin
          off      = 13'($random(seed));
          off[1:0] = lows[l];
          o = make_op(31'h100, off, codes[c], 1'b0, 1'b0, starts[s]);
          present_op(o);
          check_status(1'b1, 1'b0, 1'b0, 8'h00);
          check_val("banks", 64'(req.banks), 64'(expected_banks(codes[c], starts[s], lows[l])));
          check_request(o, 31'h2345, 31'h6789);
        end
      end
    end
  endtask

  task automatic test_addresses();
    logic [12:0] offs [0:7];
    agu_pkg::mem_op_t o;
    offs = '{13'h0040, 13'h0a84, 13'h1f00, 13'h1f80, 13'($random(seed)),
             13'($random(seed)), 13'($random(seed)), 13'($random(seed))};
    for (int i = 0; i < 8; i++) begin
      o = make_op(31'h100, offs[i], 5'd19, 1'b1, 1'b0, 5'd4);
      present_op(o);
      check_status(1'b1, 1'b0, 1'b0, 8'h00);
      check_request(o, 31'h2345, 31'h6789);
    end
  endtask

  task automatic test_faults();
    present_op(make_op(31'h200, 13'h0010, 5'd19, 1'b0, 1'b0, 5'd0));
    check_status(1'b0, 1'b0, 1'b1, 8'h01);  // not present
    present_op(make_op(31'h300, 13'h0010, 5'd19, 1'b0, 1'b0, 5'd0));
    check_status(1'b0, 1'b0, 1'b1, 8'h08);
    present_op(make_op(31'h300, 13'h0010, 5'd19, 1'b0, 1'b1, 5'd0));
    check_status(1'b1, 1'b0, 1'b0, 8'h00);  // kernel may touch sys page
    present_op(make_op(31'h400, 13'h1f84, 5'd19, 1'b1, 1'b0, 5'd0));
    check_status(1'b0, 1'b0, 1'b1, 8'h08);  // next page is sys
    present_op(make_op(31'h400, 13'h1f84, 5'd19, 1'b0, 1'b0, 5'd0));
    check_status(1'b1, 1'b0, 1'b0, 8'h00);
  endtask

  task automatic test_misses();
    present_op(make_op(31'h600, 13'h0100, 5'd19, 1'b0, 1'b0, 5'd0));
    check_status(1'b0, 1'b1, 1'b0, 8'h00);
    @(negedge clk);
    check_status(1'b0, 1'b0, 1'b0, 8'h00);  // retired after one cycle
    present_op(make_op(31'h500, 13'h1f80, 5'd19, 1'b0, 1'b0, 5'd0));
    check_status(1'b1, 1'b0, 1'b0, 8'h00);
    present_op(make_op(31'h500, 13'h1f80, 5'd19, 1'b1, 1'b0, 5'd0));
    check_status(1'b0, 1'b1, 1'b0, 8'h00);
  endtask

  task automatic test_stall_and_flush();
    agu_pkg::mem_op_t o;
    o = make_op(31'h100, 13'h0200, 5'd19, 1'b0, 1'b0, 5'd5);
    present_op(o);
    op        = make_op(31'h300, 13'h0400, 5'd19, 1'b0, 1'b1, 5'd9);
    out_stall = 1'b1;
    repeat (4) begin
      #1;
      check_status(1'b0, 1'b0, 1'b0, 8'h00);
      @(negedge clk);
    end
    op.valid  = 1'b0;
    out_stall = 1'b0;
    #1;
    check_status(1'b1, 1'b0, 1'b0, 8'h00);
    check_request(o, 31'h2345, 31'h6789);
    @(negedge clk);
    check_status(1'b0, 1'b0, 1'b0, 8'h00);  // shown only once
    present_op(o);
    except = 1'b1;
    #1;
    check_status(1'b0, 1'b0, 1'b0, 8'h00);
    @(negedge clk);
    op     = o;  // offered while flushing, never taken
    #1;
    check_status(1'b0, 1'b0, 1'b0, 8'h00);
    @(negedge clk);
    op.valid = 1'b0;
    except   = 1'b0;
    #1;
    check_status(1'b0, 1'b0, 1'b0, 8'h00);
  endtask

  task automatic test_identifiers();
    logic [23:0] ids [0:3];
    agu_pkg::mem_op_t o;
    ids = '{24'ha00001, 24'hb00002, 24'hc00003, 24'hd00004};
    write_csr(1'b0, agu_pkg::csr_page, ids[0]);
    write_csr(1'b0, agu_pkg::csr_vmpage, ids[1]);
    write_csr(1'b1, agu_pkg::csr_page, ids[2]);
    write_csr(1'b1, agu_pkg::csr_vmpage, ids[3]);
    write_csr(1'b0, 15'd5, 24'hffffff);  // other register, no effect
    for (int i = 0; i < 4; i++) begin
      o        = make_op(31'h100 + 31'(i), 13'h0020, 5'd19, 1'b0, 1'b0, 5'd0);
      o.thread = 1'(i / 2);
      o.vm     = 1'(i % 2);
      present_op(o);
      check_val("tlb_req.asid", 64'(tlb_req.asid), 64'(ids[i]));
      check_val("tlb_req.vpage", 64'(tlb_req.vpage), 64'(31'h100 + 31'(i)));
      check_status(1'b0, 1'b1, 1'b0, 8'h00);  // no entry for these ids
    end
  endtask

  initial begin
    seed      = 32;
    rst       = 1'b1;
    except    = 1'b0;
    out_stall = 1'b0;
    op        = '0;
    csr       = '0;
    add_entry(31'h100, 1'b1, 1'b0, 31'h2345);
    add_entry(31'h101, 1'b1, 1'b0, 31'h6789);
    add_entry(31'h200, 1'b0, 1'b0, 31'h0011);
    add_entry(31'h300, 1'b1, 1'b1, 31'h0022);
    add_entry(31'h400, 1'b1, 1'b0, 31'h0033);
    add_entry(31'h401, 1'b1, 1'b1, 31'h0044);
    add_entry(31'h500, 1'b1, 1'b0, 31'h0055);
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check_status(1'b0, 1'b0, 1'b0, 8'h00);
    test_bank_masks();
    test_addresses();
    test_faults();
    test_misses();
    test_stall_and_flush();
    test_identifiers();
    @(negedge clk);
    $display("checks: %0d, mismatches: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
hw/agu_pkg.sv
hw/agu_ctx_regs.sv
hw/agu_op_stage.sv
hw/agu_bank_mask.sv
hw/agu_addr_compose.sv
hw/agu_top.sv
tb/agu_tb.sv

//--- Makefile
# Verilator build and run of the address generation testbench

VERILATOR ?= verilator
TOP       ?= agu_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SOURCES := $(shell cat $(FILE_LIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
